//--- design/msi_defines.svh
`ifndef MSI_DEFINES_SVH
`define MSI_DEFINES_SVH

// AXI4-Lite address width
`define MSI_ADDR_WIDTH 40
// AXI4-Lite data width
`define MSI_DATA_WIDTH 32
// One strobe bit per data byte
`define MSI_STRB_WIDTH 4

// Interrupt line count and index width
`define MSI_NUM_IRQ 4
`define MSI_IRQ_IDX_WIDTH 2

// Per-line message identifiers
`define MSI_DEVICE_ID_WIDTH 16
`define MSI_EVENT_ID_WIDTH 16

// Throttle threshold counter width
`define MSI_THROTTLE_WIDTH 16

`endif

//--- design/msi_pkg.sv
`default_nettype none

`include "msi_defines.svh"

package msi_pkg;

  // AXI write response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Static message configuration, one ID pair per line
  typedef struct packed {
    logic [`MSI_ADDR_WIDTH-1:0]                          base_addr;
    logic [`MSI_NUM_IRQ-1:0]                             enable;
    logic [`MSI_NUM_IRQ-1:0][`MSI_DEVICE_ID_WIDTH-1:0]   device_id;
    logic [`MSI_NUM_IRQ-1:0][`MSI_EVENT_ID_WIDTH-1:0]    event_id;
  } msi_cfg_t;

  // Hold-off between messages
  typedef struct packed {
    logic                           enable;
    logic [`MSI_THROTTLE_WIDTH-1:0] threshold;
  } throttle_cfg_t;

  // One formed message, tagged with its source line
  typedef struct packed {
    logic [`MSI_ADDR_WIDTH-1:0]    addr;
    logic [`MSI_DATA_WIDTH-1:0]    data;
    logic [`MSI_STRB_WIDTH-1:0]    strb;
    logic [`MSI_IRQ_IDX_WIDTH-1:0] idx;
  } msi_req_t;

  // Manager side of AW, W and B
  typedef struct packed {
    logic [`MSI_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    logic [`MSI_DATA_WIDTH-1:0] wdata;
    logic [`MSI_STRB_WIDTH-1:0] wstrb;
    logic                       wvalid;
    logic                       bready;
  } axil_wr_req_t;

  // Subordinate side of AW, W and B
  typedef struct packed {
    logic      awready;
    logic      wready;
    axi_resp_e bresp;
    logic      bvalid;
  } axil_wr_rsp_t;

endpackage

`default_nettype wire

//--- design/msi_irq_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_irq_decode (
  input  wire                           clk,
  input  wire                           rst_n,
  // Level-sensitive interrupt lines
  input  wire [`MSI_NUM_IRQ-1:0]        irq,
  // Per-line enables from configuration
  input  wire [`MSI_NUM_IRQ-1:0]        enable,
  // Grant feedback from the execute stage
  input  wire                           clear,
  input  wire [`MSI_IRQ_IDX_WIDTH-1:0]  clear_idx,
  output logic [`MSI_NUM_IRQ-1:0]       pending
);

  logic [`MSI_NUM_IRQ-1:0] irq_masked;
  logic [`MSI_NUM_IRQ-1:0] irq_masked_q;
  logic [`MSI_NUM_IRQ-1:0] irq_rise;
  logic [`MSI_NUM_IRQ-1:0] clear_mask;

  // Disabled lines never produce an edge
  assign irq_masked = irq & enable;

  // Rising edge against last cycle's masked level
  assign irq_rise = irq_masked & ~irq_masked_q;

  // One-hot of the granted line
  always_comb begin
    clear_mask = '0;
    if (clear) begin
      clear_mask[clear_idx] = 1'b1;
    end
  end

  // Previous masked level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_masked_q <= '0;
    end else begin
      irq_masked_q <= irq_masked;
    end
  end

  // Pending bits
  // New edge wins over a same-cycle clear
  // Repeat edges merge into an already set bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clear_mask) | irq_rise;
    end
  end

endmodule

`default_nettype wire

//--- design/msi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_arbiter (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire [`MSI_NUM_IRQ-1:0]        pending,
  input  wire msi_pkg::msi_cfg_t        cfg,
  input  wire msi_pkg::throttle_cfg_t   throttle,
  // Writer took the B response
  input  wire                           done,
  // Clear strobe back to decode
  output logic                          clear,
  output logic [`MSI_IRQ_IDX_WIDTH-1:0] clear_idx,
  // Request to the writer, held until done
  output logic                          start,
  output msi_pkg::msi_req_t             req
);

  import msi_pkg::*;

  // Strobe bits covering the event ID bytes
  localparam int EventStrbWidth = (`MSI_EVENT_ID_WIDTH + 7) / 8;

  logic [`MSI_IRQ_IDX_WIDTH-1:0] ptr;
  logic [`MSI_IRQ_IDX_WIDTH-1:0] cand;
  logic [`MSI_IRQ_IDX_WIDTH-1:0] grant_idx;
  logic                          grant_found;
  logic                          grant;
  logic                          throttling;
  logic [`MSI_THROTTLE_WIDTH-1:0] throttle_cnt;
  msi_req_t                      req_nxt;

  // Round-robin search
  // First pending line at or after ptr, index wraps
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = ptr;
    cand        = ptr;
    for (int i = 0; i < `MSI_NUM_IRQ; i++) begin
      cand = ptr + `MSI_IRQ_IDX_WIDTH'(i);
      if (!grant_found && pending[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  assign throttling = (throttle_cnt != '0);

  // Only one write in flight, none while holding off
  assign grant     = !start && !throttling && grant_found;
  assign clear     = grant;
  assign clear_idx = grant_idx;

  // Message forming
  // Address steps by one word per device ID
  always_comb begin
    req_nxt.addr = cfg.base_addr + `MSI_ADDR_WIDTH'({cfg.device_id[grant_idx], 2'b00});
    req_nxt.data = `MSI_DATA_WIDTH'(cfg.event_id[grant_idx]);
    req_nxt.strb = `MSI_STRB_WIDTH'({EventStrbWidth{1'b1}});
    req_nxt.idx  = grant_idx;
  end

  // Busy flag, pointer and throttle counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start        <= 1'b0;
      ptr          <= '0;
      throttle_cnt <= '0;
    end else begin
      if (grant) begin
        start <= 1'b1;
      end else if (done) begin
        start <= 1'b0;
        // Served line goes to the back of the queue
        ptr   <= req.idx + 1'b1;
      end
      // Reload on completion, then count down to zero
      if (done && throttle.enable) begin
        throttle_cnt <= throttle.threshold;
      end else if (throttling) begin
        throttle_cnt <= throttle_cnt - 1'b1;
      end
    end
  end

  // Payload captured at grant
  always_ff @(posedge clk) begin
    if (grant) begin
      req <= req_nxt;
    end
  end

endmodule

`default_nettype wire

//--- design/msi_axil_writer.sv
`timescale 1ns/1ps
`default_nettype none

module msi_axil_writer (
  input  wire                         clk,
  input  wire                         rst_n,
  // Request from the execute stage
  input  wire                         start,
  input  wire msi_pkg::msi_req_t      req,
  // Subordinate responses
  input  wire msi_pkg::axil_wr_rsp_t  axi_rsp,
  output msi_pkg::axil_wr_req_t       axi_req,
  // One-cycle pulses after the B handshake
  output logic                        done,
  output logic                        error
);

  import msi_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_addr_data,
    st_resp
  } state_e;

  state_e   state;
  logic     aw_taken;
  logic     w_taken;
  logic     aw_done;
  logic     w_done;
  logic     accept;
  logic     b_hs;
  msi_req_t req_q;

  // Start stays high through the done cycle, skip it there
  assign accept = (state == st_idle) && start && !done;

  // Channel finished earlier or at this edge
  assign aw_done = aw_taken || (axi_req.awvalid && axi_rsp.awready);
  assign w_done  = w_taken || (axi_req.wvalid && axi_rsp.wready);
  assign b_hs    = axi_req.bready && axi_rsp.bvalid;

  // AW and W raised together, each drops on its own ready
  always_comb begin
    axi_req.awaddr  = req_q.addr;
    axi_req.awvalid = (state == st_addr_data) && !aw_taken;
    axi_req.wdata   = req_q.data;
    axi_req.wstrb   = req_q.strb;
    axi_req.wvalid  = (state == st_addr_data) && !w_taken;
    axi_req.bready  = (state == st_resp);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      aw_taken <= 1'b0;
      w_taken  <= 1'b0;
      done     <= 1'b0;
      error    <= 1'b0;
    end else begin
      done  <= b_hs;
      // Any non-OKAY response flags an error
      error <= b_hs && (axi_rsp.bresp != OKAY);
      case (state)
        st_idle: begin
          if (accept) begin
            state    <= st_addr_data;
            aw_taken <= 1'b0;
            w_taken  <= 1'b0;
          end
        end
        st_addr_data: begin
          aw_taken <= aw_done;
          w_taken  <= w_done;
          if (aw_done && w_done) begin
            state <= st_resp;
          end
        end
        st_resp: begin
          if (b_hs) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Message copy, stable while the channels wait
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

endmodule

`default_nettype wire

//--- design/msi_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_generator (
  input  wire                         clk,
  input  wire                         rst_n,
  // Interrupt lines
  input  wire [`MSI_NUM_IRQ-1:0]      irq,
  // Static configuration
  input  wire msi_pkg::msi_cfg_t      cfg,
  input  wire msi_pkg::throttle_cfg_t throttle,
  // AXI4-Lite write manager port
  input  wire msi_pkg::axil_wr_rsp_t  axi_rsp,
  output msi_pkg::axil_wr_req_t       axi_req,
  // Non-OKAY response pulse
  output logic                        error
);

  import msi_pkg::*;

  logic [`MSI_NUM_IRQ-1:0]       pending;
  logic                          clear;
  logic [`MSI_IRQ_IDX_WIDTH-1:0] clear_idx;
  logic                          start;
  logic                          done;
  msi_req_t                      req;

  // Masking, edge detect, pending bits
  msi_irq_decode u_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .irq       (irq),
    .enable    (cfg.enable),
    .clear     (clear),
    .clear_idx (clear_idx),
    .pending   (pending)
  );

  // Round-robin grant, throttle, message forming
  msi_arbiter u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .pending   (pending),
    .cfg       (cfg),
    .throttle  (throttle),
    .done      (done),
    .clear     (clear),
    .clear_idx (clear_idx),
    .start     (start),
    .req       (req)
  );

  // Single outstanding AXI4-Lite write
  msi_axil_writer u_result (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .req     (req),
    .axi_rsp (axi_rsp),
    .axi_req (axi_req),
    .done    (done),
    .error   (error)
  );

endmodule

`default_nettype wire

//--- verif/tb_msi_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module tb_msi_generator;

  import msi_pkg::*;

  logic                    clk;
  logic                    rst_n;
  logic [`MSI_NUM_IRQ-1:0] irq;
  msi_cfg_t                cfg;
  throttle_cfg_t           throttle;
  axil_wr_rsp_t            axi_rsp = '0;
  axil_wr_req_t            axi_req;
  logic                    error;

  // Subordinate knobs set per test
  int        max_delay;
  logic      rand_delay;
  axi_resp_e resp_sel;

  // Subordinate state
  int   cycle;
  int   aw_wait;
  int   aw_target;
  int   w_wait;
  int   w_target;
  int   b_count;
  int   err_count;
  int   err_cycle;
  logic awvalid_q;

  // Taken payloads and handshake times
  // One entry per write
  logic [`MSI_ADDR_WIDTH-1:0] aw_addr_q[$];
  logic [`MSI_DATA_WIDTH-1:0] w_data_q[$];
  logic [`MSI_STRB_WIDTH-1:0] w_strb_q[$];
  int                         b_cycle_q[$];
  int                         rise_cycle_q[$];

  msi_generator u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .irq      (irq),
    .cfg      (cfg),
    .throttle (throttle),
    .axi_rsp  (axi_rsp),
    .axi_req  (axi_req),
    .error    (error)
  );

  always #2 clk = ~clk;

  // Ready delay in cycles
  // Fixed or random up to max_delay
  function automatic int next_delay();
    if (rand_delay) begin
      return int'($urandom % (max_delay + 1));
    end else begin
      return max_delay;
    end
  endfunction

  // AXI4-Lite subordinate with delayed readies
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      axi_rsp   <= '0;
      aw_wait   = 0;
      w_wait    = 0;
      awvalid_q <= 1'b0;
    end else begin
      // AW channel
      if (axi_req.awvalid && axi_rsp.awready) begin
        aw_addr_q.push_back(axi_req.awaddr);
        axi_rsp.awready <= 1'b0;
        aw_wait = 0;
      end else if (axi_req.awvalid) begin
        if (aw_wait == 0) aw_target = next_delay();
        if (aw_wait >= aw_target) axi_rsp.awready <= 1'b1;
        else aw_wait = aw_wait + 1;
      end
      // W channel independent of AW
      if (axi_req.wvalid && axi_rsp.wready) begin
        w_data_q.push_back(axi_req.wdata);
        w_strb_q.push_back(axi_req.wstrb);
        axi_rsp.wready <= 1'b0;
        w_wait = 0;
      end else if (axi_req.wvalid) begin
        if (w_wait == 0) w_target = next_delay();
        if (w_wait >= w_target) axi_rsp.wready <= 1'b1;
        else w_wait = w_wait + 1;
      end
      // B channel answers as soon as bready shows
      if (axi_rsp.bvalid && axi_req.bready) begin
        axi_rsp.bvalid <= 1'b0;
        b_cycle_q.push_back(cycle);
        b_count = b_count + 1;
      end else if (axi_req.bready) begin
        axi_rsp.bvalid <= 1'b1;
        axi_rsp.bresp  <= resp_sel;
      end
      // Start of each write on the bus
      if (axi_req.awvalid && !awvalid_q) rise_cycle_q.push_back(cycle);
      awvalid_q <= axi_req.awvalid;
      if (error) begin
        err_count = err_count + 1;
        err_cycle = cycle;
      end
      cycle = cycle + 1;
    end
  end

  task automatic stop_with_fail(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_int(input string name, input int exp, input int got);
    if (exp != got) begin
      stop_with_fail($sformatf("Fail %s exp 0x%0h got 0x%0h", name, exp, got));
    end
  endtask

  task automatic compare_resp(input string name, input axi_resp_e exp, input axi_resp_e got);
    if (exp != got) begin
      stop_with_fail($sformatf("Fail %s exp 0x%0h got 0x%0h", name, exp, got));
    end
  endtask

  // Payload fields only
  // Field idx just labels the line
  task automatic compare_msg(input msi_req_t exp, input msi_req_t got);
    if (exp.addr != got.addr) begin
      stop_with_fail($sformatf("Fail awaddr line %0d exp 0x%0h got 0x%0h",
                               exp.idx, exp.addr, got.addr));
    end
    if (exp.data != got.data) begin
      stop_with_fail($sformatf("Fail wdata line %0d exp 0x%0h got 0x%0h",
                               exp.idx, exp.data, got.data));
    end
    if (exp.strb != got.strb) begin
      stop_with_fail($sformatf("Fail wstrb line %0d exp 0x%0h got 0x%0h",
                               exp.idx, exp.strb, got.strb));
    end
  endtask

  // Base plus one 32-bit word per device ID
  function automatic msi_req_t expected_msg(input logic [`MSI_IRQ_IDX_WIDTH-1:0] line);
    msi_req_t m;
    m.addr = cfg.base_addr + (`MSI_ADDR_WIDTH'(cfg.device_id[line]) << 2);
    m.data = {16'h0000, cfg.event_id[line]};
    // Event ID is two bytes wide
    m.strb = 4'b0011;
    m.idx  = line;
    return m;
  endfunction

  // Error pulses seen mean a non-OKAY response
  function automatic axi_resp_e resp_from_pulses(input int pulses);
    if (pulses > 0) begin
      return SLVERR;
    end else begin
      return OKAY;
    end
  endfunction

  task automatic check_write(input int n, input logic [`MSI_IRQ_IDX_WIDTH-1:0] line);
    msi_req_t got;
    got.addr = aw_addr_q[n];
    got.data = w_data_q[n];
    got.strb = w_strb_q[n];
    got.idx  = line;
    compare_msg(expected_msg(line), got);
  endtask

  task automatic wait_writes(input int total);
    int waited;
    waited = 0;
    while (b_count < total && waited < 500) begin
      @(negedge clk);
      waited++;
    end
    if (b_count < total) stop_with_fail("Timed out waiting for a write response handshake");
  endtask

  // One-cycle high level on the given lines
  task automatic pulse_irq(input logic [`MSI_NUM_IRQ-1:0] lines);
    @(posedge clk);
    irq <= lines;
    @(posedge clk);
    irq <= '0;
  endtask

  task automatic idle_after_reset();
    repeat (20) begin
      @(negedge clk);
      compare_int("axi_req.awvalid", 0, int'(axi_req.awvalid));
      compare_int("axi_req.wvalid", 0, int'(axi_req.wvalid));
      compare_int("axi_req.bready", 0, int'(axi_req.bready));
      compare_int("error", 0, int'(error));
    end
  endtask

  task automatic single_message();
    int base;
    int edges;
    base = b_count;
    @(posedge clk);
    irq <= 4'b0100;
    // Edge that samples the rise
    @(posedge clk);
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!axi_req.awvalid && edges < 20);
    compare_int("edges to awvalid", 2, edges);
    @(posedge clk);
    irq <= '0;
    wait_writes(base + 1);
    repeat (30) @(negedge clk);
    compare_int("write count", base + 1, b_count);
    check_write(base, 2'd2);
  endtask

  task automatic mask_and_merge();
    int base;
    base = b_count;
    @(posedge clk);
    cfg.enable <= 4'b1101;
    max_delay  <= 8;
    @(posedge clk);
    irq <= 4'b0100;
    // Line 1 is masked
    // Line 3 rises twice while line 2 is served
    @(posedge clk);
    irq <= 4'b1110;
    @(posedge clk);
    irq <= 4'b0100;
    @(posedge clk);
    irq <= 4'b1110;
    @(posedge clk);
    irq <= '0;
    wait_writes(base + 2);
    repeat (40) @(negedge clk);
    compare_int("write count", base + 2, b_count);
    check_write(base, 2'd2);
    check_write(base + 1, 2'd3);
    @(posedge clk);
    cfg.enable <= 4'b1111;
    max_delay  <= 0;
  endtask

  task automatic round_robin_order();
    int base;
    base = b_count;
    // Pointer sits at line 0 after line 3
    pulse_irq(4'b1111);
    wait_writes(base + 4);
    check_write(base, 2'd0);
    check_write(base + 1, 2'd1);
    check_write(base + 2, 2'd2);
    check_write(base + 3, 2'd3);
    pulse_irq(4'b0101);
    wait_writes(base + 6);
    repeat (30) @(negedge clk);
    compare_int("write count", base + 6, b_count);
    check_write(base + 4, 2'd0);
    check_write(base + 5, 2'd2);
  endtask

  task automatic throttle_under_backpressure();
    int base;
    int gap;
    base = b_count;
    @(posedge clk);
    throttle.enable    <= 1'b1;
    throttle.threshold <= 16'd10;
    rand_delay         <= 1'b1;
    max_delay          <= 5;
    // Line 2 was last so line 3 leads
    pulse_irq(4'b1111);
    wait_writes(base + 4);
    check_write(base, 2'd3);
    check_write(base + 1, 2'd0);
    check_write(base + 2, 2'd1);
    check_write(base + 3, 2'd2);
    for (int k = 1; k < 4; k++) begin
      gap = rise_cycle_q[base + k] - b_cycle_q[base + k - 1];
      if (gap < 10) stop_with_fail($sformatf("Next write started only %0d cycles after B", gap));
    end
    @(posedge clk);
    throttle.enable <= 1'b0;
    rand_delay      <= 1'b0;
    max_delay       <= 0;
    // Let the last hold-off run out
    repeat (20) @(negedge clk);
  endtask

  task automatic error_response();
    int base;
    base = b_count;
    compare_int("error pulse count", 0, err_count);
    @(posedge clk);
    resp_sel <= SLVERR;
    pulse_irq(4'b0010);
    wait_writes(base + 1);
    repeat (5) @(negedge clk);
    compare_int("error pulse count", 1, err_count);
    compare_int("error pulse cycle", b_cycle_q[base] + 1, err_cycle);
    check_write(base, 2'd1);
    @(posedge clk);
    resp_sel <= OKAY;
    pulse_irq(4'b0010);
    wait_writes(base + 2);
    repeat (5) @(negedge clk);
    compare_resp("bresp", OKAY, resp_from_pulses(err_count - 1));
    check_write(base + 1, 2'd1);
  endtask

  initial begin
    clk                = 1'b0;
    rst_n              = 1'b0;
    irq                = '0;
    cfg                = '0;
    cfg.base_addr      = 40'h12_3400_0000;
    cfg.enable         = 4'b1111;
    cfg.device_id[0]   = 16'h0010;
    cfg.device_id[1]   = 16'h0123;
    cfg.device_id[2]   = 16'h0A05;
    cfg.device_id[3]   = 16'hFFFF;
    cfg.event_id[0]    = 16'h0041;
    cfg.event_id[1]    = 16'h1234;
    cfg.event_id[2]    = 16'h8001;
    cfg.event_id[3]    = 16'hBEEF;
    throttle           = '0;
    max_delay          = 0;
    rand_delay         = 1'b0;
    resp_sel           = OKAY;
    void'($urandom(41));
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    idle_after_reset();
    single_message();
    mask_and_merge();
    round_robin_order();
    throttle_under_backpressure();
    error_response();
    // Every completed write took exactly one AW and one W
    compare_int("aw handshake count", b_count, aw_addr_q.size());
    compare_int("w handshake count", b_count, w_data_q.size());
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/msi_pkg.sv
design/msi_irq_decode.sv
design/msi_arbiter.sv
design/msi_axil_writer.sv
design/msi_generator.sv
verif/tb_msi_generator.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_msi_generator
FILELIST  := filelist.f
VFLAGS    := --binary --timing --timescale 1ns/1ps
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
